// ==== src/axi_mem_consts.svh ====
//////////////////////////////////////////////////
// widths, memory depth and response codes shared
// by the AXI4 memory slave and its testbench
//////////////////////////////////////////////////

`ifndef AXI_MEM_CONSTS_SVH
`define AXI_MEM_CONSTS_SVH

// address, data and ID widths of the AXI4 port
`define AXI_MEM_AW (32)
`define AXI_MEM_DW (64)
`define AXI_MEM_IW (4)
// one strobe bit per data byte
`define AXI_MEM_SW (8)
// burst length field wide enough for the 256 beats AXI4 allows
`define AXI_MEM_LW (8)

// memory depth counted in full data words, and the index width that covers it
`define AXI_MEM_WORDS (1024)
`define AXI_MEM_IDX_W (10)

// the two response codes this slave ever returns
`define AXI_MEM_RESP_OKAY   (2'b00)
`define AXI_MEM_RESP_SLVERR (2'b10)

`endif

// ==== src/axi_mem_pkg.sv ====
//////////////////////////////////////////////////
// burst, response and FSM state enums plus the
// AXI channel and request/response packed structs
//////////////////////////////////////////////////

`include "axi_mem_consts.svh"

package axi_mem_pkg;

  // burst encodings as AXI defines them
  // the engines walk WRAP like INCR
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = `AXI_MEM_RESP_OKAY,
    RESP_SLVERR = `AXI_MEM_RESP_SLVERR
  } resp_e;

  // one address beat layout serves both AW and AR
  typedef struct packed {
    logic [`AXI_MEM_IW-1:0] id;
    logic [`AXI_MEM_AW-1:0] addr;
    logic [`AXI_MEM_LW-1:0] len;
    burst_e                 burst;
  } ax_chan_t;

  typedef struct packed {
    logic [`AXI_MEM_DW-1:0] data;
    logic [`AXI_MEM_SW-1:0] strb;
    logic                   last;
  } w_chan_t;

  typedef struct packed {
    logic [`AXI_MEM_IW-1:0] id;
    resp_e                  resp;
  } b_chan_t;

  typedef struct packed {
    logic [`AXI_MEM_IW-1:0] id;
    logic [`AXI_MEM_DW-1:0] data;
    resp_e                  resp;
    logic                   last;
  } r_chan_t;

  // everything the master drives toward the slave
  typedef struct packed {
    ax_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ax_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  // everything the slave drives back
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    logic    ar_ready;
    r_chan_t r;
    logic    r_valid;
  } axi_resp_t;

  typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_e;

  typedef enum logic [1:0] {RD_IDLE, RD_FETCH, RD_SEND} rd_state_e;

endpackage

// ==== src/axi_mem_array.sv ====
//////////////////////////////////////////////////
// dual-port word memory, byte-strobed write port
// and a registered read port
//////////////////////////////////////////////////

`include "axi_mem_consts.svh"

module axi_mem_array (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      we_i,
  input  logic [`AXI_MEM_IDX_W-1:0] wr_idx_i,
  input  logic [`AXI_MEM_DW-1:0]    wdata_i,
  input  logic [`AXI_MEM_SW-1:0]    wstrb_i,
  input  logic                      re_i,
  input  logic [`AXI_MEM_IDX_W-1:0] rd_idx_i,
  output logic [`AXI_MEM_DW-1:0]    rdata_o
);

  // storage keeps whatever it held across reset
  logic [`AXI_MEM_DW-1:0] mem_q [`AXI_MEM_WORDS];

  // only the bytes whose strobe is set take the new value
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      for (int b = 0; b < `AXI_MEM_SW; b++) begin
        if (wstrb_i[b]) begin
          mem_q[wr_idx_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // the read samples the array before this edge's write lands,
  // so a same-word collision returns the old contents
  // without re_i the output register keeps its word, which lets the
  // read engine hold r_data while the master stalls
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rdata_o <= '0;
    end else if (re_i) begin
      rdata_o <= mem_q[rd_idx_i];
    end
  end

endmodule

// ==== src/axi_mem_write.sv ====
//////////////////////////////////////////////////
// AW/W/B burst engine that walks the burst
// addresses, writes each beat and returns one
// B response
//////////////////////////////////////////////////

`include "axi_mem_consts.svh"

module axi_mem_write (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  axi_mem_pkg::axi_req_t     req_i,
  output logic                      aw_ready_o,
  output logic                      w_ready_o,
  output axi_mem_pkg::b_chan_t      b_o,
  output logic                      b_valid_o,
  output logic                      we_o,
  output logic [`AXI_MEM_IDX_W-1:0] wr_idx_o,
  output logic [`AXI_MEM_DW-1:0]    wdata_o,
  output logic [`AXI_MEM_SW-1:0]    wstrb_o
);

  // byte offset bits below the word index
  localparam int unsigned OFF_W = $clog2(`AXI_MEM_SW);
  localparam logic [`AXI_MEM_AW-1:0] STEP = `AXI_MEM_SW;

  axi_mem_pkg::wr_state_e state_q;
  axi_mem_pkg::wr_state_e state_d;
  logic                   aw_ready_q;
  logic [`AXI_MEM_IW-1:0] id_q;
  logic [`AXI_MEM_AW-1:0] addr_q;
  logic [`AXI_MEM_LW-1:0] len_q;
  logic [`AXI_MEM_LW-1:0] cnt_q;
  axi_mem_pkg::burst_e    burst_q;
  logic                   err_q;
  logic                   aw_hs;
  logic                   w_hs;
  logic                   b_hs;
  logic                   in_range;
  logic                   last_beat;

  assign aw_ready_o = aw_ready_q;
  assign w_ready_o  = (state_q == axi_mem_pkg::WR_DATA);
  assign b_valid_o  = (state_q == axi_mem_pkg::WR_RESP);

  assign aw_hs = req_i.aw_valid & aw_ready_o;
  assign w_hs  = req_i.w_valid & w_ready_o;
  assign b_hs  = b_valid_o & req_i.b_ready;

  // any address bit above the word index means the beat misses the memory
  assign in_range  = (addr_q[`AXI_MEM_AW-1:OFF_W+`AXI_MEM_IDX_W] == '0);
  // the beat count alone ends the burst and w_last is not looked at
  assign last_beat = (cnt_q == len_q);

  // out-of-range beats are accepted on W but never reach the array
  assign we_o     = w_hs & in_range;
  assign wr_idx_o = addr_q[OFF_W +: `AXI_MEM_IDX_W];
  assign wdata_o  = req_i.w.data;
  assign wstrb_o  = req_i.w.strb;

  assign b_o.id   = id_q;
  assign b_o.resp = err_q ? axi_mem_pkg::RESP_SLVERR : axi_mem_pkg::RESP_OKAY;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      axi_mem_pkg::WR_IDLE: if (aw_hs) state_d = axi_mem_pkg::WR_DATA;
      axi_mem_pkg::WR_DATA: if (w_hs && last_beat) state_d = axi_mem_pkg::WR_RESP;
      axi_mem_pkg::WR_RESP: if (b_hs) state_d = axi_mem_pkg::WR_IDLE;
      default: state_d = axi_mem_pkg::WR_IDLE;
    endcase
  end

  // aw_ready is registered from the next state, so it stays low for the
  // first cycle after reset and falls in the same edge as the AW handshake
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= axi_mem_pkg::WR_IDLE;
      aw_ready_q <= 1'b0;
      cnt_q      <= '0;
      err_q      <= 1'b0;
    end else begin
      state_q    <= state_d;
      aw_ready_q <= (state_d == axi_mem_pkg::WR_IDLE);
      if (aw_hs) begin
        cnt_q <= '0;
        err_q <= 1'b0;
      end else if (w_hs) begin
        // the error flag is sticky so one bad beat turns the whole burst into SLVERR
        err_q <= err_q | ~in_range;
        if (!last_beat) cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // burst attributes come from AW and then the address walks beat by beat
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      id_q    <= req_i.aw.id;
      addr_q  <= req_i.aw.addr;
      len_q   <= req_i.aw.len;
      burst_q <= req_i.aw.burst;
    end else if (w_hs && burst_q != axi_mem_pkg::BURST_FIXED) begin
      addr_q <= addr_q + STEP;
    end
  end

endmodule

// ==== src/axi_mem_read.sv ====
//////////////////////////////////////////////////
// AR/R burst engine with one array read per beat
// and data held steady while the master stalls
//////////////////////////////////////////////////

`include "axi_mem_consts.svh"

module axi_mem_read (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  axi_mem_pkg::axi_req_t     req_i,
  output logic                      ar_ready_o,
  output axi_mem_pkg::r_chan_t      r_o,
  output logic                      r_valid_o,
  output logic                      re_o,
  output logic [`AXI_MEM_IDX_W-1:0] rd_idx_o,
  input  logic [`AXI_MEM_DW-1:0]    rdata_i
);

  localparam int unsigned OFF_W = $clog2(`AXI_MEM_SW);
  localparam logic [`AXI_MEM_AW-1:0] STEP = `AXI_MEM_SW;

  axi_mem_pkg::rd_state_e state_q;
  axi_mem_pkg::rd_state_e state_d;
  logic                   ar_ready_q;
  logic [`AXI_MEM_IW-1:0] id_q;
  logic [`AXI_MEM_AW-1:0] addr_q;
  logic [`AXI_MEM_LW-1:0] len_q;
  logic [`AXI_MEM_LW-1:0] cnt_q;
  axi_mem_pkg::burst_e    burst_q;
  logic                   ar_hs;
  logic                   r_hs;
  logic                   in_range;
  logic                   last_beat;

  assign ar_ready_o = ar_ready_q;
  assign r_valid_o  = (state_q == axi_mem_pkg::RD_SEND);

  assign ar_hs = req_i.ar_valid & ar_ready_o;
  assign r_hs  = r_valid_o & req_i.r_ready;

  // addr_q only moves on an accepted beat, so through SEND it still
  // names the beat on the bus and the range check can stay combinational
  assign in_range  = (addr_q[`AXI_MEM_AW-1:OFF_W+`AXI_MEM_IDX_W] == '0);
  assign last_beat = (cnt_q == len_q);

  // FETCH lasts exactly one cycle and loads the array's output register
  assign re_o     = (state_q == axi_mem_pkg::RD_FETCH);
  assign rd_idx_o = addr_q[OFF_W +: `AXI_MEM_IDX_W];

  // the array holds its output while re_o is low, which keeps the
  // data stable across any number of stalled cycles
  assign r_o.id   = id_q;
  assign r_o.data = in_range ? rdata_i : '0;
  assign r_o.resp = in_range ? axi_mem_pkg::RESP_OKAY : axi_mem_pkg::RESP_SLVERR;
  assign r_o.last = last_beat;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      axi_mem_pkg::RD_IDLE: if (ar_hs) state_d = axi_mem_pkg::RD_FETCH;
      axi_mem_pkg::RD_FETCH: state_d = axi_mem_pkg::RD_SEND;
      axi_mem_pkg::RD_SEND: begin
        // after the final beat the engine is free again, otherwise
        // it spends one cycle fetching the next word
        if (r_hs) begin
          state_d = last_beat ? axi_mem_pkg::RD_IDLE : axi_mem_pkg::RD_FETCH;
        end
      end
      default: state_d = axi_mem_pkg::RD_IDLE;
    endcase
  end

  // ar_ready follows the next state one edge ahead, low right after
  // reset and low for the whole burst
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= axi_mem_pkg::RD_IDLE;
      ar_ready_q <= 1'b0;
      cnt_q      <= '0;
    end else begin
      state_q    <= state_d;
      ar_ready_q <= (state_d == axi_mem_pkg::RD_IDLE);
      if (ar_hs) begin
        cnt_q <= '0;
      end else if (r_hs && !last_beat) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // FIXED bursts reread the same word on every beat
  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      id_q    <= req_i.ar.id;
      addr_q  <= req_i.ar.addr;
      len_q   <= req_i.ar.len;
      burst_q <= req_i.ar.burst;
    end else if (r_hs && burst_q != axi_mem_pkg::BURST_FIXED) begin
      addr_q <= addr_q + STEP;
    end
  end

endmodule

// ==== src/axi_mem_top.sv ====
//////////////////////////////////////////////////
// AXI4 memory slave top: flat ports packed into
// request/response structs, both burst engines
// and the shared word memory
//////////////////////////////////////////////////

`include "axi_mem_consts.svh"

module axi_mem_top (
  input  logic                   clk_i,
  input  logic                   reset_i,
  // write address
  input  logic [`AXI_MEM_IW-1:0] aw_id_i,
  input  logic [`AXI_MEM_AW-1:0] aw_addr_i,
  input  logic [`AXI_MEM_LW-1:0] aw_len_i,
  input  logic [2:0]             aw_size_i,
  input  logic [1:0]             aw_burst_i,
  input  logic                   aw_lock_i,
  input  logic [3:0]             aw_cache_i,
  input  logic [2:0]             aw_prot_i,
  input  logic [3:0]             aw_qos_i,
  input  logic [3:0]             aw_region_i,
  input  logic                   aw_valid_i,
  output logic                   aw_ready_o,
  // write data
  input  logic [`AXI_MEM_DW-1:0] w_data_i,
  input  logic [`AXI_MEM_SW-1:0] w_strb_i,
  input  logic                   w_last_i,
  input  logic                   w_valid_i,
  output logic                   w_ready_o,
  // write response
  output logic [`AXI_MEM_IW-1:0] b_id_o,
  output logic [1:0]             b_resp_o,
  output logic                   b_user_o,
  output logic                   b_valid_o,
  input  logic                   b_ready_i,
  // read address
  input  logic [`AXI_MEM_IW-1:0] ar_id_i,
  input  logic [`AXI_MEM_AW-1:0] ar_addr_i,
  input  logic [`AXI_MEM_LW-1:0] ar_len_i,
  input  logic [2:0]             ar_size_i,
  input  logic [1:0]             ar_burst_i,
  input  logic                   ar_lock_i,
  input  logic [3:0]             ar_cache_i,
  input  logic [2:0]             ar_prot_i,
  input  logic [3:0]             ar_qos_i,
  input  logic [3:0]             ar_region_i,
  input  logic                   ar_valid_i,
  output logic                   ar_ready_o,
  // read data
  output logic [`AXI_MEM_IW-1:0] r_id_o,
  output logic [`AXI_MEM_DW-1:0] r_data_o,
  output logic [1:0]             r_resp_o,
  output logic                   r_last_o,
  output logic                   r_user_o,
  output logic                   r_valid_o,
  input  logic                   r_ready_i
);

  // each engine drives its own fields of the response struct
  wire axi_mem_pkg::axi_req_t  axi_req;
  wire axi_mem_pkg::axi_resp_t axi_resp;

  logic                      we;
  logic [`AXI_MEM_IDX_W-1:0] wr_idx;
  logic [`AXI_MEM_DW-1:0]    wdata;
  logic [`AXI_MEM_SW-1:0]    wstrb;
  logic                      re;
  logic [`AXI_MEM_IDX_W-1:0] rd_idx;
  logic [`AXI_MEM_DW-1:0]    rdata;

  // size, lock, cache, prot, qos and region have no field in the structs,
  // every beat is full width and the attributes change nothing here
  assign axi_req.aw.id    = aw_id_i;
  assign axi_req.aw.addr  = aw_addr_i;
  assign axi_req.aw.len   = aw_len_i;
  assign axi_req.aw.burst = axi_mem_pkg::burst_e'(aw_burst_i);
  assign axi_req.aw_valid = aw_valid_i;
  assign axi_req.w.data   = w_data_i;
  assign axi_req.w.strb   = w_strb_i;
  assign axi_req.w.last   = w_last_i;
  assign axi_req.w_valid  = w_valid_i;
  assign axi_req.b_ready  = b_ready_i;
  assign axi_req.ar.id    = ar_id_i;
  assign axi_req.ar.addr  = ar_addr_i;
  assign axi_req.ar.len   = ar_len_i;
  assign axi_req.ar.burst = axi_mem_pkg::burst_e'(ar_burst_i);
  assign axi_req.ar_valid = ar_valid_i;
  assign axi_req.r_ready  = r_ready_i;

  assign aw_ready_o = axi_resp.aw_ready;
  assign w_ready_o  = axi_resp.w_ready;
  assign b_id_o     = axi_resp.b.id;
  assign b_resp_o   = axi_resp.b.resp;
  assign b_valid_o  = axi_resp.b_valid;
  assign ar_ready_o = axi_resp.ar_ready;
  assign r_id_o     = axi_resp.r.id;
  assign r_data_o   = axi_resp.r.data;
  assign r_resp_o   = axi_resp.r.resp;
  assign r_last_o   = axi_resp.r.last;
  assign r_valid_o  = axi_resp.r_valid;
  // no user sideband is carried
  assign b_user_o   = 1'b0;
  assign r_user_o   = 1'b0;

  axi_mem_write u_write (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .req_i      (axi_req),
    .aw_ready_o (axi_resp.aw_ready),
    .w_ready_o  (axi_resp.w_ready),
    .b_o        (axi_resp.b),
    .b_valid_o  (axi_resp.b_valid),
    .we_o       (we),
    .wr_idx_o   (wr_idx),
    .wdata_o    (wdata),
    .wstrb_o    (wstrb)
  );

  axi_mem_read u_read (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .req_i      (axi_req),
    .ar_ready_o (axi_resp.ar_ready),
    .r_o        (axi_resp.r),
    .r_valid_o  (axi_resp.r_valid),
    .re_o       (re),
    .rd_idx_o   (rd_idx),
    .rdata_i    (rdata)
  );

  axi_mem_array u_array (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .we_i     (we),
    .wr_idx_i (wr_idx),
    .wdata_i  (wdata),
    .wstrb_i  (wstrb),
    .re_i     (re),
    .rd_idx_i (rd_idx),
    .rdata_o  (rdata)
  );

endmodule

// ==== verif/axi_mem_chk.sv ====
//////////////////////////////////////////////////
// concurrent assertions on the AXI channel rules,
// bound into the memory slave top
//////////////////////////////////////////////////

`include "axi_mem_consts.svh"

module axi_mem_chk (
  input logic                   clk_i,
  input logic                   reset_i,
  input logic [`AXI_MEM_IW-1:0] aw_id_i,
  input logic [`AXI_MEM_AW-1:0] aw_addr_i,
  input logic [`AXI_MEM_LW-1:0] aw_len_i,
  input logic [1:0]             aw_burst_i,
  input logic                   aw_valid_i,
  input logic                   aw_ready_o,
  input logic [`AXI_MEM_DW-1:0] w_data_i,
  input logic [`AXI_MEM_SW-1:0] w_strb_i,
  input logic                   w_last_i,
  input logic                   w_valid_i,
  input logic                   w_ready_o,
  input logic [`AXI_MEM_IW-1:0] b_id_o,
  input logic [1:0]             b_resp_o,
  input logic                   b_valid_o,
  input logic                   b_ready_i,
  input logic [`AXI_MEM_IW-1:0] ar_id_i,
  input logic [`AXI_MEM_AW-1:0] ar_addr_i,
  input logic [`AXI_MEM_LW-1:0] ar_len_i,
  input logic [1:0]             ar_burst_i,
  input logic                   ar_valid_i,
  input logic                   ar_ready_o,
  input logic [`AXI_MEM_IW-1:0] r_id_o,
  input logic [`AXI_MEM_DW-1:0] r_data_o,
  input logic [1:0]             r_resp_o,
  input logic                   r_last_o,
  input logic                   r_valid_o,
  input logic                   r_ready_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // a raised valid keeps itself and its payload until the handshake edge
  aw_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    aw_valid_i && !aw_ready_o |=> aw_valid_i && $stable({aw_id_i, aw_addr_i, aw_len_i, aw_burst_i}))
    else $error("AW valid or payload moved before its handshake");

  w_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    w_valid_i && !w_ready_o |=> w_valid_i && $stable({w_data_i, w_strb_i, w_last_i}))
    else $error("W valid or payload moved before its handshake");

  ar_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    ar_valid_i && !ar_ready_o |=>
      ar_valid_i && $stable({ar_id_i, ar_addr_i, ar_len_i, ar_burst_i}))
    else $error("AR valid or payload moved before its handshake");

  b_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable({b_id_o, b_resp_o}))
    else $error("B valid or payload moved while the master stalled");

  r_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable({r_id_o, r_data_o, r_resp_o, r_last_o}))
    else $error("R valid or payload moved while the master stalled");

  // every reset edge leaves both response channels quiet for the next cycle
  rsp_reset: assert property (@(posedge clk_i) reset_i |=> !b_valid_o && !r_valid_o)
    else $error("response valid high during or just after reset");

  // the read engine takes no new AR while a beat is still on the bus
  ar_busy: assert property (@(posedge clk_i) disable iff (reset_i) r_valid_o |-> !ar_ready_o)
    else $error("ar_ready high while r_valid is high");

endmodule

// ==== verif/axi_mem_tb.sv ====
//////////////////////////////////////////////////
// testbench for the AXI4 memory slave with a
// transaction table, master tasks, reference
// memory, value checks, watchdog and verdict
//////////////////////////////////////////////////

`include "axi_mem_consts.svh"

module axi_mem_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int IDX_W = `AXI_MEM_IDX_W;
  localparam int WORD_BYTES = `AXI_MEM_DW / 8;
  localparam int MEM_BYTES = `AXI_MEM_WORDS * WORD_BYTES;
  // cycles any single handshake may take before it counts as lost
  localparam int HS_LIMIT = 64;
  localparam bit WR = 1'b1;
  localparam bit RD = 1'b0;
  localparam logic [1:0] OKAY = `AXI_MEM_RESP_OKAY;
  localparam logic [1:0] SLVERR = `AXI_MEM_RESP_SLVERR;
  localparam logic [1:0] FIXED = axi_mem_pkg::BURST_FIXED;
  localparam logic [1:0] INCR = axi_mem_pkg::BURST_INCR;

  // each row of the transaction table carries the expected B or burst response in resp
  typedef struct packed {
    bit                     is_write;
    logic [`AXI_MEM_IW-1:0] id;
    logic [`AXI_MEM_AW-1:0] addr;
    logic [`AXI_MEM_LW-1:0] len;
    logic [1:0]             burst;
    logic [`AXI_MEM_SW-1:0] strb;
    logic [31:0]            seed;
    logic [1:0]             resp;
  } txn_t;

  logic clk_i;
  logic reset_i;
  logic [`AXI_MEM_IW-1:0] aw_id_i, ar_id_i, b_id_o, r_id_o;
  logic [`AXI_MEM_AW-1:0] aw_addr_i, ar_addr_i;
  logic [`AXI_MEM_LW-1:0] aw_len_i, ar_len_i;
  logic [2:0] aw_size_i, ar_size_i, aw_prot_i, ar_prot_i;
  logic [1:0] aw_burst_i, ar_burst_i, b_resp_o, r_resp_o;
  logic [3:0] aw_cache_i, ar_cache_i, aw_qos_i, ar_qos_i, aw_region_i, ar_region_i;
  logic aw_lock_i, ar_lock_i, aw_valid_i, ar_valid_i, aw_ready_o, ar_ready_o;
  logic [`AXI_MEM_DW-1:0] w_data_i, r_data_o;
  logic [`AXI_MEM_SW-1:0] w_strb_i;
  logic w_last_i, w_valid_i, w_ready_o;
  logic b_user_o, b_valid_o, b_ready_i;
  logic r_last_o, r_user_o, r_valid_o, r_ready_i;

  txn_t txns[$];
  bit table_ready;
  int seed;
  int checks;
  int mismatches;
  int hs_fails;
  // what the master saw on the last accepted B or R beat
  logic [`AXI_MEM_IW-1:0] cap_id;
  logic [`AXI_MEM_DW-1:0] cap_data;
  logic [1:0] cap_resp;
  logic cap_last;
  logic cap_user;
  // expected memory contents where words the table never writes stay unknown
  logic [`AXI_MEM_DW-1:0] ref_mem [`AXI_MEM_WORDS];

  axi_mem_top DUT (.*);

  bind axi_mem_top axi_mem_chk u_chk (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic add_txn(input bit wr, input logic [3:0] id, input logic [31:0] addr,
                         input logic [7:0] len, input logic [1:0] burst,
                         input logic [7:0] strb, input logic [31:0] seed_v,
                         input logic [1:0] resp);
    txn_t t;
    t.is_write = wr;
    t.id = id;
    t.addr = addr;
    t.len = len;
    t.burst = burst;
    t.strb = strb;
    t.seed = seed_v;
    t.resp = resp;
    txns.push_back(t);
  endtask

  task automatic load_table();
    // plain INCR write and read back, then partial strobes merged into it
    add_txn(WR, 4'h1, 32'h0000_0100, 8'd3, INCR, 8'hff, 32'h1111_0001, OKAY);
    add_txn(RD, 4'h2, 32'h0000_0100, 8'd3, INCR, 8'h00, 32'h0, OKAY);
    add_txn(WR, 4'h3, 32'h0000_0108, 8'd0, INCR, 8'h0f, 32'h2222_0002, OKAY);
    add_txn(WR, 4'h4, 32'h0000_0110, 8'd1, INCR, 8'ha5, 32'h3333_0003, OKAY);
    add_txn(RD, 4'h5, 32'h0000_0100, 8'd3, INCR, 8'h00, 32'h0, OKAY);
    // FIXED bursts keep hitting one word
    add_txn(WR, 4'h6, 32'h0000_01f0, 8'd1, INCR, 8'hff, 32'h4444_0004, OKAY);
    add_txn(WR, 4'h7, 32'h0000_0200, 8'd3, FIXED, 8'hff, 32'h5555_0005, OKAY);
    add_txn(RD, 4'h8, 32'h0000_0200, 8'd2, FIXED, 8'h00, 32'h0, OKAY);
    add_txn(RD, 4'h9, 32'h0000_01f0, 8'd2, INCR, 8'h00, 32'h0, OKAY);
    // bursts that run past the top of memory
    add_txn(WR, 4'ha, 32'h0000_1ff0, 8'd3, INCR, 8'hff, 32'h6666_0006, SLVERR);
    add_txn(RD, 4'hb, 32'h0000_1ff0, 8'd3, INCR, 8'h00, 32'h0, SLVERR);
    // 0x2100 aliases onto 0x100 if the upper bits were dropped
    add_txn(WR, 4'hc, 32'h0000_2100, 8'd1, INCR, 8'h3c, 32'h7777_0007, SLVERR);
    add_txn(RD, 4'hd, 32'h0000_0100, 8'd1, INCR, 8'h00, 32'h0, OKAY);
    add_txn(RD, 4'hf, 32'h0000_3ff8, 8'd1, FIXED, 8'h00, 32'h0, SLVERR);
    add_txn(WR, 4'h0, 32'h0000_0118, 8'd1, FIXED, 8'hc3, 32'h8888_0008, OKAY);
    add_txn(RD, 4'he, 32'h0000_0110, 8'd1, INCR, 8'h00, 32'h0, OKAY);
  endtask

  function automatic logic [31:0] beat_addr(input txn_t t, input int k);
    // WRAP walks like INCR in this slave
    if (t.burst == FIXED) begin
      return t.addr;
    end
    return t.addr + 32'(k * WORD_BYTES);
  endfunction

  function automatic bit addr_in_mem(input logic [31:0] a);
    return a < MEM_BYTES;
  endfunction

  function automatic logic [IDX_W-1:0] word_index(input logic [31:0] a);
    return IDX_W'(a / WORD_BYTES);
  endfunction

  function automatic logic [63:0] beat_data(input logic [31:0] base, input int k);
    return {base ^ (32'h9e37_79b9 * k), base + 32'(k)};
  endfunction

  function automatic bit pick_ready();
    // roughly one cycle in four is a stall
    return ($random(seed) & 3) != 0;
  endfunction

  function automatic bit ready_of(input string chan);
    if (chan == "AW") begin
      return aw_ready_o;
    end else if (chan == "W") begin
      return w_ready_o;
    end
    return ar_ready_o;
  endfunction

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_stall(input string chan, input int i);
    hs_fails++;
    $display("%s handshake of transaction %0d never happened within %0d cycles",
             chan, i, HS_LIMIT);
  endtask

  // with valid already up, ready is sampled at the falling edge so the
  // rising edge after it is known to carry the handshake
  task automatic await_ready(input string chan, output bit ok);
    int n;
    n = 0;
    ok = 1'b0;
    while (!ok && n < HS_LIMIT) begin
      @(negedge clk_i);
      ok = ready_of(chan);
      @(posedge clk_i);
      #0.5;
      n++;
    end
  endtask

  // B and R beats are captured at the falling edge, before the
  // handshake edge lets the slave move on
  task automatic await_response(input bit read_chan, output bit ok);
    int n;
    n = 0;
    ok = 1'b0;
    while (!ok && n < HS_LIMIT) begin
      if (read_chan) begin
        r_ready_i = pick_ready();
      end else begin
        b_ready_i = pick_ready();
      end
      @(negedge clk_i);
      if (read_chan) begin
        ok = r_valid_o && r_ready_i;
        cap_id = r_id_o;
        cap_data = r_data_o;
        cap_resp = r_resp_o;
        cap_last = r_last_o;
        cap_user = r_user_o;
      end else begin
        ok = b_valid_o && b_ready_i;
        cap_id = b_id_o;
        cap_resp = b_resp_o;
        cap_user = b_user_o;
      end
      @(posedge clk_i);
      #0.5;
      n++;
    end
    b_ready_i = 1'b0;
    r_ready_i = 1'b0;
  endtask

  task automatic run_write(input int i);
    txn_t t;
    logic [31:0] a;
    logic [63:0] d;
    bit ok;
    t = txns[i];
    aw_id_i = t.id;
    aw_addr_i = t.addr;
    aw_len_i = t.len;
    aw_burst_i = t.burst;
    aw_valid_i = 1'b1;
    await_ready("AW", ok);
    aw_valid_i = 1'b0;
    if (!ok) begin
      report_stall("AW", i);
      return;
    end
    for (int k = 0; k <= t.len; k++) begin
      a = beat_addr(t, k);
      d = beat_data(t.seed, k);
      w_data_i = d;
      w_strb_i = t.strb;
      w_last_i = (k == t.len);
      w_valid_i = 1'b1;
      await_ready("W", ok);
      if (!ok) begin
        w_valid_i = 1'b0;
        report_stall("W", i);
        return;
      end
      // the reference memory takes the beat byte by byte and drops beats off the end
      if (addr_in_mem(a)) begin
        for (int b = 0; b < WORD_BYTES; b++) begin
          if (t.strb[b]) begin
            ref_mem[word_index(a)][8*b +: 8] = d[8*b +: 8];
          end
        end
      end
    end
    w_valid_i = 1'b0;
    w_last_i = 1'b0;
    await_response(1'b0, ok);
    if (!ok) begin
      report_stall("B", i);
      return;
    end
    check($sformatf("txn %0d b_id", i), 64'(cap_id), 64'(t.id));
    check($sformatf("txn %0d b_resp", i), 64'(cap_resp), 64'(t.resp));
    check($sformatf("txn %0d b_user", i), 64'(cap_user), 64'h0);
  endtask

  task automatic run_read(input int i);
    txn_t t;
    logic [31:0] a;
    logic [63:0] exp_data;
    logic [1:0] exp_resp;
    bit saw_err;
    bit ok;
    t = txns[i];
    ar_id_i = t.id;
    ar_addr_i = t.addr;
    ar_len_i = t.len;
    ar_burst_i = t.burst;
    ar_valid_i = 1'b1;
    await_ready("AR", ok);
    ar_valid_i = 1'b0;
    if (!ok) begin
      report_stall("AR", i);
      return;
    end
    saw_err = 1'b0;
    for (int k = 0; k <= t.len; k++) begin
      a = beat_addr(t, k);
      await_response(1'b1, ok);
      if (!ok) begin
        report_stall("R", i);
        return;
      end
      if (addr_in_mem(a)) begin
        exp_data = ref_mem[word_index(a)];
        exp_resp = OKAY;
      end else begin
        exp_data = '0;
        exp_resp = SLVERR;
      end
      saw_err = saw_err | (cap_resp == SLVERR);
      check($sformatf("txn %0d beat %0d r_data", i, k), cap_data, exp_data);
      check($sformatf("txn %0d beat %0d r_resp", i, k), 64'(cap_resp), 64'(exp_resp));
      check($sformatf("txn %0d beat %0d r_last", i, k), 64'(cap_last), 64'(k == t.len));
      check($sformatf("txn %0d beat %0d r_id", i, k), 64'(cap_id), 64'(t.id));
      check($sformatf("txn %0d beat %0d r_user", i, k), 64'(cap_user), 64'h0);
    end
    // the table states whether some beat of the burst must fail
    check($sformatf("txn %0d burst response", i), 64'(saw_err ? SLVERR : OKAY), 64'(t.resp));
  endtask

  initial begin
    reset_i = 1'b1;
    aw_id_i = '0;
    aw_addr_i = '0;
    aw_len_i = '0;
    aw_size_i = 3'd3;
    aw_burst_i = INCR;
    aw_lock_i = 1'b0;
    aw_cache_i = '0;
    aw_prot_i = '0;
    aw_qos_i = '0;
    aw_region_i = '0;
    aw_valid_i = 1'b0;
    w_data_i = '0;
    w_strb_i = '0;
    w_last_i = 1'b0;
    w_valid_i = 1'b0;
    b_ready_i = 1'b0;
    ar_id_i = '0;
    ar_addr_i = '0;
    ar_len_i = '0;
    ar_size_i = 3'd3;
    ar_burst_i = INCR;
    ar_lock_i = 1'b0;
    ar_cache_i = '0;
    ar_prot_i = '0;
    ar_qos_i = '0;
    ar_region_i = '0;
    ar_valid_i = 1'b0;
    r_ready_i = 1'b0;
    seed = 32'hf36d7c8f;
    checks = 0;
    mismatches = 0;
    hs_fails = 0;
    load_table();
    table_ready = 1'b1;
    repeat (4) @(posedge clk_i);
    #0.5;
    reset_i = 1'b0;
    foreach (txns[i]) begin
      if (txns[i].is_write) begin
        run_write(i);
      end else begin
        run_read(i);
      end
    end
    repeat (4) @(posedge clk_i);
    $display("checks %0d, mismatches %0d, handshake failures %0d",
             checks, mismatches, hs_fails);
    if (mismatches == 0 && hs_fails == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // the budget grows with the table and gives each beat a generous 40 cycles
  initial begin : watchdog
    int max_len;
    int limit;
    wait (table_ready);
    max_len = 0;
    foreach (txns[i]) begin
      if (txns[i].len > max_len) begin
        max_len = txns[i].len;
      end
    end
    limit = txns.size() * (max_len + 1) * 40;
    repeat (limit) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, the run did not finish", limit);
    $display("** FAIL **");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+src
src/axi_mem_pkg.sv
src/axi_mem_array.sv
src/axi_mem_write.sv
src/axi_mem_read.sv
src/axi_mem_top.sv
verif/axi_mem_chk.sv
verif/axi_mem_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the AXI memory slave testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
  -f compile.f --top-module axi_mem_tb -o axi_mem_sim
out=$(./obj_dir/axi_mem_sim || true)
echo "$out"
if echo "$out" | grep -qF '** PASS **'; then
  exit 0
fi
exit 1
